// File: files.f
+incdir+source
source/mpu_pkg.sv
source/ring_buffer_ctrl.sv
source/stride_address_gen.sv
source/extern_data_service.sv
source/data_memory.sv
source/mpu_data_subsystem.sv
verification/clock_gen.sv
verification/mpu_props.sv
verification/tb_top.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the MPU data subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f files.f -o tb_top_sim \
	> build.log 2>&1 \
	&& ./obj_dir/tb_top_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "sim passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

// File: verification/tb_top.sv
//////////////////////////////
// Testbench of the MPU data subsystem
// Loads only read addresses stored before
// Stops at the first mismatch
//////////////////////////////
`include "mpu_defines.svh"

module tb_top;

	import mpu_pkg::*;

	typedef logic [`MPU_BUFF_PTR_WIDTH:0] length_t;

	localparam int mem_words      = 2**`MPU_ADDR_WIDTH;
	localparam int num_commands   = 40;
	localparam int cycles_per_cmd = 60;
	localparam int timeout_cycles = num_commands * cycles_per_cmd + 20;	// Reset included

	logic	clock;
	logic	reset;
	beat_t	ext_in;
	beat_t	ext_out;
	logic	busy;

	data_t	model_mem [mem_words];
	data_t	expect_q [$];	// Load words still to come out
	string	test_name;
	int		cycle_count = 0;
	int		i;

	clock_gen clk_gen0 (.clock(clock));

	mpu_data_subsystem dut0 (
		.clock		(clock),
		.reset		(reset),
		.ext_in		(ext_in),
		.ext_out	(ext_out),
		.busy		(busy)
	);

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// One word with a random gap before it
	task automatic send_word(input data_t word);
		repeat ($urandom_range(0, 2)) @(negedge clock);
		ext_in = '{valid: 1'b1, data: word};
		@(negedge clock);
		ext_in = '{valid: 1'b0, data: '0};
	endtask

	task automatic send_command(input logic [1:0] op, input addr_t stride,
		input length_t length, input addr_t base);
		data_t op_word;
		op_word = $urandom;	// Upper bits are ignored
		op_word[1:0] = op;
		send_word(op_word);
		send_word(data_t'(stride));
		send_word(data_t'(length));
		send_word(data_t'(base));
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clock);
		repeat (3) @(negedge clock);	// Extra beats would show up here
		check_value("missing output beats", 0, expect_q.size());
	endtask

	task automatic run_store(input addr_t base, input addr_t stride, input length_t length);
		addr_t addr;
		data_t word;
		int n;
		send_command(op_store, stride, length, base);
		addr = base;
		for (n = 0; n < int'(length); n++) begin
			word = $urandom;
			model_mem[addr] = word;
			send_word(word);
			addr = addr + stride;	// Wraps at memory size
		end
		wait_idle();
	endtask

	task automatic run_load(input addr_t base, input addr_t stride, input length_t length);
		addr_t addr;
		int n;
		addr = base;
		for (n = 0; n < int'(length); n++) begin
			expect_q.push_back(model_mem[addr]);
			addr = addr + stride;
		end
		send_command(op_load, stride, length, base);
		wait_idle();
	endtask

	task automatic run_noop(input logic [1:0] op);
		send_command(op, addr_t'($urandom), length_t'($urandom_range(1, `MPU_BUFF_DEPTH)),
			addr_t'($urandom));
		check_value("busy after no-op base word", 0, 32'(busy));
		wait_idle();
	endtask

	//////////////////////////////
	// Output monitor and timeout
	always @(negedge clock) begin
		if (!reset && ext_out.valid === 1'b1) begin
			if (expect_q.size() == 0) begin
				$display("Unexpected output beat %h during %s", ext_out.data, test_name);
				$display("sim failed");
				$fatal(1, "extra output beat");
			end else begin
				check_value("load data", expect_q.pop_front(), ext_out.data);
			end
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("Timeout, the run took more than %0d cycles", timeout_cycles);
			$display("sim failed");
			$fatal(1, "run did not finish");
		end
	end

	//////////////////////////////
	// Stimulus
	initial begin
		void'($urandom(59105));
		reset = 1'b1;
		ext_in = '{valid: 1'b0, data: '0};
		test_name = "reset";
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (i = 0; i < 5; i++) begin
			@(negedge clock);
			check_value("busy", 0, 32'(busy));
			check_value("output valid", 0, 32'(ext_out.valid));
		end

		test_name = "linear blocks";
		for (i = 0; i < 4; i++) run_store(addr_t'(i * 16), 6'd1, length_t'(16));
		for (i = 0; i < 4; i++) run_load(addr_t'(i * 16), 6'd1, length_t'(16));

		test_name = "random store and load";
		for (i = 0; i < 4; i++) begin
			addr_t base;
			addr_t stride;
			length_t length;
			base = addr_t'($urandom);
			stride = addr_t'($urandom);
			length = length_t'($urandom_range(1, `MPU_BUFF_DEPTH));
			run_store(base, stride, length);
			run_load(base, stride, length);
		end

		test_name = "full length load";
		for (i = 0; i < 2; i++) run_load(addr_t'($urandom), addr_t'($urandom), length_t'(16));

		test_name = "no-op commands";
		run_noop(2'd0);
		run_load(addr_t'($urandom), 6'd1, length_t'(16));
		run_noop(2'd3);
		run_load(addr_t'($urandom), 6'd3, length_t'(16));

		test_name = "mixed commands";
		for (i = 0; i < 18; i++) begin
			if ($urandom_range(0, 1) == 1) begin
				run_store(addr_t'($urandom), addr_t'($urandom),
					length_t'($urandom_range(1, `MPU_BUFF_DEPTH)));
			end else begin
				run_load(addr_t'($urandom), addr_t'($urandom),
					length_t'($urandom_range(1, `MPU_BUFF_DEPTH)));
			end
		end

		$display("sim passed");
		$finish;
	end

endmodule

// File: verification/mpu_props.sv
//////////////////////////////
// Buffer and memory handshake checks
// Bound into extern_data_service
//////////////////////////////

module mpu_props (
	input logic	clock,
	input logic	reset,
	input logic	busy,
	input logic	buff_write,
	input logic	buff_full,
	input logic	buff_empty,
	input logic	mem_req,
	input logic	mem_grant,
	input logic	mem_rls
);

	//////////////////////////////
	// Ring buffer
	no_write_full: assert property (@(posedge clock) disable iff (reset)
		!(buff_write && buff_full)) else $error("buffer written while full");

	// Every word has left by the time the command ends
	empty_when_idle: assert property (@(posedge clock) disable iff (reset)
		!busy |-> buff_empty) else $error("buffer holds data while the service is idle");

	// Memory handshake
	grant_after_req: assert property (@(posedge clock) disable iff (reset)
		$rose(mem_req) |=> $rose(mem_grant)) else $error("grant not one cycle after request");

	rls_in_grant: assert property (@(posedge clock) disable iff (reset)
		mem_rls |-> mem_grant) else $error("release outside of grant");

endmodule

bind extern_data_service mpu_props props0 (
	.clock		(clock),
	.reset		(reset),
	.busy		(busy),
	.buff_write	(buff_write),
	.buff_full	(buff_full),
	.buff_empty	(buff_empty),
	.mem_req	(mem_req),
	.mem_grant	(mem_grant),
	.mem_rls	(mem_rls)
);

// File: verification/clock_gen.sv
//////////////////////////////
// Free running testbench clock
// Period of 100 time units
//////////////////////////////

module clock_gen (
	output logic	clock
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

endmodule

// File: source/mpu_data_subsystem.sv
//////////////////////////////
// Data service joined to its memory
// Start commands only while busy is low
//////////////////////////////

module mpu_data_subsystem (
	input  logic			clock,
	input  logic			reset,
	input  mpu_pkg::beat_t	ext_in,
	output mpu_pkg::beat_t	ext_out,
	output logic			busy
);

	import mpu_pkg::*;

	// Memory side
	logic		mem_req;
	logic		mem_grant;
	logic		mem_rls;
	mem_cmd_t	mem_cmd;
	beat_t		mem_wr;
	beat_t		mem_rd;

	extern_data_service service0 (
		.clock		(clock),
		.reset		(reset),
		.ext_in		(ext_in),
		.ext_out	(ext_out),
		.busy		(busy),
		.mem_req	(mem_req),
		.mem_cmd	(mem_cmd),
		.mem_grant	(mem_grant),
		.mem_rls	(mem_rls),
		.mem_rd		(mem_rd),
		.mem_wr		(mem_wr)
	);

	data_memory memory0 (
		.clock		(clock),
		.reset		(reset),
		.mem_req	(mem_req),
		.mem_cmd	(mem_cmd),
		.mem_wr		(mem_wr),
		.mem_grant	(mem_grant),
		.mem_rd		(mem_rd),
		.mem_rls	(mem_rls)
	);

endmodule

// File: source/data_memory.sv
//////////////////////////////
// Word memory behind the data service
// No initial contents, read data one cycle late
//////////////////////////////
`include "mpu_defines.svh"

module data_memory (
	input  logic				clock,
	input  logic				reset,
	input  logic				mem_req,
	input  mpu_pkg::mem_cmd_t	mem_cmd,
	input  mpu_pkg::beat_t		mem_wr,
	output logic				mem_grant,
	output mpu_pkg::beat_t		mem_rd,
	output logic				mem_rls
);

	import mpu_pkg::*;

	data_t	mem [2**`MPU_ADDR_WIDTH];
	addr_t	addr;
	logic	last;
	logic	start;
	logic	wr_en;
	logic	rd_en;
	logic	rd_last;	// Final read beat leaves this cycle
	logic	rd_valid;
	data_t	rd_data;

	assign start = mem_req & ~mem_grant;	// Generator loads as grant rises
	assign wr_en = mem_grant & (mem_cmd.op == op_store) & mem_wr.valid;
	assign rd_en = mem_grant & (mem_cmd.op == op_load) & ~rd_last;

	// Store releases on the last write, load with the last data beat
	assign mem_rls = (wr_en & last) | rd_last;
	assign mem_rd  = '{valid: rd_valid, data: rd_data};

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_grant <= 1'b0;
			rd_valid  <= 1'b0;
			rd_last   <= 1'b0;
		end else begin
			mem_grant <= mem_req & ~mem_rls;
			rd_valid  <= rd_en;
			rd_last   <= rd_en & last;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[addr] <= mem_wr.data;
		end
		if (rd_en) begin
			rd_data <= mem[addr];
		end
	end

	stride_address_gen addr_gen (
		.clock	(clock),
		.reset	(reset),
		.start	(start),
		.cmd	(mem_cmd),
		.step	(wr_en | rd_en),
		.addr	(addr),
		.last	(last)
	);

endmodule

// File: source/extern_data_service.sv
//////////////////////////////
// External command port of the data memory
// Length must not exceed the buffer depth
// Output has no back-pressure
//////////////////////////////
`include "mpu_defines.svh"

module extern_data_service (
	input  logic				clock,
	input  logic				reset,
	input  mpu_pkg::beat_t		ext_in,
	output mpu_pkg::beat_t		ext_out,
	output logic				busy,
	output logic				mem_req,
	output mpu_pkg::mem_cmd_t	mem_cmd,
	input  logic				mem_grant,
	input  logic				mem_rls,
	input  mpu_pkg::beat_t		mem_rd,
	output mpu_pkg::beat_t		mem_wr
);

	import mpu_pkg::*;

	serv_state_e	serv_state;
	xfer_state_e	xfer_state;
	mem_cmd_t		cmd_q;
	mpu_op_e		op_word;
	logic			req_q;

	logic [`MPU_BUFF_PTR_WIDTH:0]	store_count;	// Store data words accepted

	logic	is_store;
	logic	is_load;
	logic	cmd_start;
	logic	store_accept;
	logic	load_fill;
	logic	store_done;
	logic	drain_done;

	// Buffer
	data_t							buff_mem [`MPU_BUFF_DEPTH];
	data_t							buff_wdata;
	logic							buff_write;
	logic							buff_read;
	logic [`MPU_BUFF_PTR_WIDTH-1:0]	buff_write_ptr;
	logic [`MPU_BUFF_PTR_WIDTH-1:0]	buff_read_ptr;
	logic [`MPU_BUFF_PTR_WIDTH:0]	buff_count;
	logic							buff_full;
	logic							buff_empty;

	// Unknown opcodes fall to none
	always_comb begin
		case (mpu_op_e'(ext_in.data[1:0]))
			op_store: op_word = op_store;
			op_load:  op_word = op_load;
			default:  op_word = op_none;
		endcase
	end

	assign is_store  = (cmd_q.op == op_store);
	assign is_load   = (cmd_q.op == op_load);
	assign cmd_start = (serv_state == serv_base) & ext_in.valid & (cmd_q.op != op_none);

	//////////////////////////////
	// Buffer traffic
	assign store_accept = (serv_state == serv_run) & is_store & ext_in.valid
		& (store_count != cmd_q.length);
	assign load_fill    = (xfer_state == xfer_run) & is_load & mem_rd.valid;
	assign buff_write   = store_accept | load_fill;
	assign buff_wdata   = store_accept ? ext_in.data : mem_rd.data;
	assign buff_read    = ~buff_empty & ((xfer_state == xfer_run) | (xfer_state == xfer_drain));

	assign store_done = (xfer_state == xfer_run) & is_store & mem_rls;
	assign drain_done = (xfer_state == xfer_drain) & (buff_count == '0);

	always_ff @(posedge clock) begin
		if (buff_write) begin
			buff_mem[buff_write_ptr] <= buff_wdata;
		end
	end

	// Head goes out on whichever port the command selects
	assign ext_out = '{valid: buff_read & is_load, data: buff_mem[buff_read_ptr]};
	assign mem_wr  = '{valid: buff_read & is_store, data: buff_mem[buff_read_ptr]};

	assign busy    = (serv_state != serv_idle);
	assign mem_req = req_q;
	assign mem_cmd = cmd_q;

	//////////////////////////////
	// Command capture
	always_ff @(posedge clock) begin
		if (reset) begin
			serv_state <= serv_idle;
			cmd_q      <= '0;
		end else begin
			case (serv_state)
				serv_idle: if (ext_in.valid) begin
					cmd_q.op   <= op_word;
					serv_state <= serv_stride;
				end
				serv_stride: if (ext_in.valid) begin
					cmd_q.stride <= ext_in.data[`MPU_ADDR_WIDTH-1:0];
					serv_state   <= serv_length;
				end
				serv_length: if (ext_in.valid) begin
					cmd_q.length <= ext_in.data[`MPU_BUFF_PTR_WIDTH:0];
					serv_state   <= serv_base;
				end
				serv_base: if (ext_in.valid) begin
					cmd_q.base <= ext_in.data[`MPU_ADDR_WIDTH-1:0];
					serv_state <= (cmd_q.op != op_none) ? serv_run : serv_idle;	// No-op ends here
				end
				serv_run: if (store_done | drain_done) begin
					serv_state <= serv_idle;
				end
				default: serv_state <= serv_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			store_count <= '0;
		end else if (cmd_start) begin
			store_count <= '0;
		end else if (store_accept) begin
			store_count <= store_count + 1'b1;
		end
	end

	// Request held until the memory releases
	always_ff @(posedge clock) begin
		if (reset) begin
			req_q <= 1'b0;
		end else if (mem_rls) begin
			req_q <= 1'b0;
		end else if (cmd_start) begin
			req_q <= 1'b1;
		end
	end

	//////////////////////////////
	// Transfer control
	always_ff @(posedge clock) begin
		if (reset) begin
			xfer_state <= xfer_idle;
		end else begin
			case (xfer_state)
				xfer_idle:       if (cmd_start) xfer_state <= xfer_wait_grant;
				xfer_wait_grant: if (mem_grant) xfer_state <= xfer_run;
				xfer_run: if (mem_rls) begin
					xfer_state <= is_load ? xfer_drain : xfer_idle;
				end
				xfer_drain:      if (drain_done) xfer_state <= xfer_idle;
				default:         xfer_state <= xfer_idle;
			endcase
		end
	end

	ring_buffer_ctrl buff_ctrl (
		.clock		(clock),
		.reset		(reset),
		.write_en	(buff_write),
		.read_en	(buff_read),
		.write_ptr	(buff_write_ptr),
		.read_ptr	(buff_read_ptr),
		.count		(buff_count),
		.full		(buff_full),
		.empty		(buff_empty)
	);

endmodule

// File: source/stride_address_gen.sv
//////////////////////////////
// Strided address sequence for one command
// Step only while beats remain
//////////////////////////////
`include "mpu_defines.svh"

module stride_address_gen (
	input  logic				clock,
	input  logic				reset,
	input  logic				start,	// One-cycle pulse
	input  mpu_pkg::mem_cmd_t	cmd,
	input  logic				step,
	output mpu_pkg::addr_t		addr,
	output logic				last
);

	import mpu_pkg::*;

	addr_t							next_addr;
	logic [`MPU_BUFF_PTR_WIDTH:0]	remain;	// Current beat included

	assign next_addr = addr + cmd.stride;	// Wraps modulo memory size

	//////////////////////////////
	// Address register
	always_ff @(posedge clock) begin
		if (start) begin
			addr <= cmd.base;
		end else if (step) begin
			addr <= next_addr;
		end
	end

	// Beat countdown
	always_ff @(posedge clock) begin
		if (reset) begin
			remain <= '0;
		end else if (start) begin
			remain <= cmd.length;
		end else if (step && remain != '0) begin
			remain <= remain - 1'b1;
		end
	end

	assign last = (remain == 1);

endmodule

// File: source/ring_buffer_ctrl.sv
//////////////////////////////
// Pointers and occupancy of the service buffer
// Write while full or read while empty is illegal
//////////////////////////////
`include "mpu_defines.svh"

module ring_buffer_ctrl (
	input  logic							clock,
	input  logic							reset,
	input  logic							write_en,
	input  logic							read_en,
	output logic [`MPU_BUFF_PTR_WIDTH-1:0]	write_ptr,
	output logic [`MPU_BUFF_PTR_WIDTH-1:0]	read_ptr,
	output logic [`MPU_BUFF_PTR_WIDTH:0]	count,
	output logic							full,
	output logic							empty
);

	localparam logic [`MPU_BUFF_PTR_WIDTH:0] depth = `MPU_BUFF_DEPTH;

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			write_ptr <= '0;
		end else if (write_en) begin
			write_ptr <= write_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			read_ptr <= '0;
		end else if (read_en) begin
			read_ptr <= read_ptr + 1'b1;
		end
	end

	// Occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({write_en, read_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	assign full  = (count == depth);
	assign empty = (count == '0);

endmodule

// File: source/mpu_pkg.sv
//////////////////////////////
// Types shared by service and memory
// Command length runs 1 to the buffer depth
//////////////////////////////
`include "mpu_defines.svh"

package mpu_pkg;

	typedef logic [`MPU_DATA_WIDTH-1:0] data_t;
	typedef logic [`MPU_ADDR_WIDTH-1:0] addr_t;	// Arithmetic wraps at memory size

	// Low two bits of the first command word
	typedef enum logic [1:0] {
		op_none		= 2'd0,
		op_store	= 2'd1,
		op_load		= 2'd2
	} mpu_op_e;

	// Command word capture
	typedef enum logic [2:0] {
		serv_idle,
		serv_stride,
		serv_length,
		serv_base,
		serv_run
	} serv_state_e;

	typedef enum logic [1:0] {
		xfer_idle,
		xfer_wait_grant,
		xfer_run,
		xfer_drain	// Load only, empties the buffer after release
	} xfer_state_e;

	typedef struct packed {
		logic	valid;
		data_t	data;
	} beat_t;

	typedef struct packed {
		mpu_op_e						op;
		addr_t							stride;
		logic [`MPU_BUFF_PTR_WIDTH:0]	length;	// 1 to buffer depth
		addr_t							base;
	} mem_cmd_t;

endpackage

// File: source/mpu_defines.svh
//////////////////////////////
// Sizes of the MPU data service and memory
// Buffer depth must be 2**BUFF_PTR_WIDTH
//////////////////////////////
`ifndef MPU_DEFINES_SVH
`define MPU_DEFINES_SVH

// Data word and memory address
`define MPU_DATA_WIDTH		32
`define MPU_ADDR_WIDTH		6	// 64 words

//////////////////////////////
// Service ring buffer
`define MPU_BUFF_DEPTH		16
`define MPU_BUFF_PTR_WIDTH	4	// Count is one bit wider

`endif
